// File: common/ctrl_pkg.sv
// shared types for the core controller: fsm states, pc select, jump kind and operand source
package ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // controller state machine
  //////////////////////////////////////////////////////////////////////

  // reset and boot come first so that an all-zero register is RESET
  typedef enum logic [2:0] {
    RESET       = 3'd0,
    BOOT_SET    = 3'd1,
    SLEEP       = 3'd2,
    FIRST_FETCH = 3'd3,
    DECODE      = 3'd4,
    FLUSH_EX    = 3'd5,
    FLUSH_WB    = 3'd6
  } ctrl_state_t;

  //////////////////////////////////////////////////////////////////////
  // fetch stage pc source
  //////////////////////////////////////////////////////////////////////

  // encoding matches the pc mux in the fetch stage
  // 3'b001 and 3'b111 are unused here
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_t;

  //////////////////////////////////////////////////////////////////////
  // decoder jump classification
  //////////////////////////////////////////////////////////////////////

  // conditional branches resolve in EX, jal and jalr resolve in ID
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_t;

  //////////////////////////////////////////////////////////////////////
  // operand forwarding source
  //////////////////////////////////////////////////////////////////////

  // regfile read, alu result from EX, or writeback data
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_t;

endpackage

// File: src/hazard_unit.sv
// hazard unit: load-use and jump-register stalls, regfile write-enable deassert
`timescale 1ns/1ps

module hazard_unit (
  input  logic                 is_decoding_i,
  input  logic                 illegal_insn_i,
  input  logic                 data_req_ex_i,
  input  logic                 regfile_we_ex_i,
  input  logic                 regfile_we_wb_i,
  input  logic                 regfile_alu_we_fw_i,
  input  logic                 reg_d_wb_is_reg_a_i,
  input  logic                 reg_d_alu_is_reg_a_i,
  input  logic                 reg_d_alu_is_reg_b_i,
  input  ctrl_pkg::jump_kind_t jump_in_dec_i,
  output logic                 load_stall_o,
  output logic                 jr_stall_o,
  output logic                 deassert_we_o
);
  import ctrl_pkg::*;

  logic wb_hits_a;
  logic ex_hits_a;
  logic alu_hits_a;

  //////////////////////////////////////////////////////////////////////
  // load-use
  //////////////////////////////////////////////////////////////////////

  // load in EX writes a register read in ID, data not back yet
  assign load_stall_o = data_req_ex_i && regfile_we_ex_i &&
                        (reg_d_alu_is_reg_a_i || reg_d_alu_is_reg_b_i);

  //////////////////////////////////////////////////////////////////////
  // jump register
  //////////////////////////////////////////////////////////////////////

  // jalr target is computed in ID, so any pending write of rs1 blocks it
  assign wb_hits_a  = regfile_we_wb_i && reg_d_wb_is_reg_a_i;
  // EX and ALU writes share the same destination compare
  assign ex_hits_a  = regfile_we_ex_i && reg_d_alu_is_reg_a_i;
  assign alu_hits_a = regfile_alu_we_fw_i && reg_d_alu_is_reg_a_i;

  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) &&
                      (wb_hits_a || ex_hits_a || alu_hits_a);

  //////////////////////////////////////////////////////////////////////
  // write-enable deassert
  //////////////////////////////////////////////////////////////////////

  // no regfile write from an instruction that is not really issued
  assign deassert_we_o = !is_decoding_i || illegal_insn_i ||
                         load_stall_o || jr_stall_o;

endmodule

// File: src/fwd_unit.sv
// forwarding unit: operand a and b source select from EX and WB write matches
`timescale 1ns/1ps

module fwd_unit (
  input  logic              regfile_we_wb_i,
  input  logic              regfile_alu_we_fw_i,
  input  logic              reg_d_wb_is_reg_a_i,
  input  logic              reg_d_wb_is_reg_b_i,
  input  logic              reg_d_alu_is_reg_a_i,
  input  logic              reg_d_alu_is_reg_b_i,
  output ctrl_pkg::fw_sel_t operand_a_fw_mux_sel_o,
  output ctrl_pkg::fw_sel_t operand_b_fw_mux_sel_o
);
  import ctrl_pkg::*;

  // priority pick for one operand
  // EX holds the younger result, so it beats WB
  function automatic fw_sel_t pick_src(input logic alu_hit, input logic wb_hit);
    fw_sel_t sel;
    if (alu_hit) begin
      sel = SEL_FW_EX;
    end else if (wb_hit) begin
      sel = SEL_FW_WB;
    end else begin
      sel = SEL_REGFILE;
    end
    return sel;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // per operand select
  //////////////////////////////////////////////////////////////////////

  // a match only counts when that stage really writes the regfile
  assign operand_a_fw_mux_sel_o = pick_src(regfile_alu_we_fw_i && reg_d_alu_is_reg_a_i,
                                           regfile_we_wb_i && reg_d_wb_is_reg_a_i);

  assign operand_b_fw_mux_sel_o = pick_src(regfile_alu_we_fw_i && reg_d_alu_is_reg_b_i,
                                           regfile_we_wb_i && reg_d_wb_is_reg_b_i);

endmodule

// File: ctrl_fsm/ctrl_fsm.sv
// core control fsm: boot, decode, flush and sleep with pc redirection and exception strobes
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_enable_i,
  input  logic                 instr_valid_i,
  input  logic                 eret_insn_i,
  input  logic                 pipe_flush_i,
  input  logic                 branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_t jump_in_dec_i,
  input  logic                 exc_req_i,
  input  logic                 ext_req_i,
  input  logic                 id_ready_i,
  input  logic                 ex_valid_i,
  input  logic                 jr_stall_i,
  output logic                 ctrl_busy_o,
  output logic                 is_decoding_o,
  output logic                 instr_req_o,
  output logic                 pc_set_o,
  output ctrl_pkg::pc_mux_t    pc_mux_o,
  output logic                 exc_ack_o,
  output logic                 exc_save_if_o,
  output logic                 exc_save_id_o,
  output logic                 exc_save_takenbranch_o,
  output logic                 exc_restore_id_o,
  output logic                 halt_if_o,
  output logic                 halt_id_o
);
  import ctrl_pkg::*;

  ctrl_state_t state_q, state_d;
  // set once a jump or eret has redirected the pc for the instruction in ID
  logic jump_done_q, jump_done_d;
  logic is_jump;

  assign is_jump = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  //////////////////////////////////////////////////////////////////////
  // next state and output decode
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    // defaults: busy and fetching, no redirect
    state_d                = state_q;
    jump_done_d            = jump_done_q;
    ctrl_busy_o            = 1'b1;
    is_decoding_o          = 1'b0;
    instr_req_o            = 1'b1;
    pc_set_o               = 1'b0;
    pc_mux_o               = PC_BOOT;
    exc_ack_o              = 1'b0;
    exc_save_if_o          = 1'b0;
    exc_save_id_o          = 1'b0;
    exc_save_takenbranch_o = 1'b0;
    exc_restore_id_o       = 1'b0;
    halt_if_o              = 1'b0;
    halt_id_o              = 1'b0;

    unique case (state_q)
      // idle after reset until the core is enabled
      RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load the boot address into the fetch pc, one cycle
      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // pipeline is empty, wait for enable or an interrupt
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req_i) begin
          state_d = FIRST_FETCH;
        end
      end

      // first instruction on its way, stay here while IF misses
      FIRST_FETCH: begin
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // interrupt on wake-up: nothing in ID yet, so save the IF pc
        if (exc_req_i) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE: begin
        // only decode when no taken branch in EX kills the ID instruction
        if (instr_valid_i && !branch_taken_ex_i) begin
          is_decoding_o = 1'b1;

          if (is_jump) begin
            pc_mux_o = PC_JUMP;
            // jalr waits for its base register, and redirect only once
            if (!jr_stall_i && !jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end else if (exc_req_i) begin
            // exception taken on the instruction in ID
            pc_set_o      = 1'b1;
            pc_mux_o      = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end

          // return from exception, restore the saved pc
          if (eret_insn_i) begin
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end

          // wfi style flush, also eret back into sleep
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i)) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // empty ID slot: interrupt resumes at the IF pc
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
          // keep the bubble out of EX
          halt_id_o     = 1'b1;
        end

        // taken branch in EX overrides anything decoded in ID
        if (branch_taken_ex_i) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_BRANCH;
          is_decoding_o = 1'b0;
          // interrupt resumes at the branch target
          if (ext_req_i) begin
            pc_mux_o               = PC_EXCEPTION;
            exc_ack_o              = 1'b1;
            exc_save_takenbranch_o = 1'b1;
            halt_id_o              = 1'b1;
          end
        end
      end

      // nop into EX until the last instruction leaves it
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = FLUSH_WB;
        end
      end

      // one more cycle for WB, then resume or sleep
      FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end else begin
          state_d = SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state and jump-done registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // ID moving on means a new instruction, so the flag is cleared
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

// File: src/riscv_ctrl.sv
// controller top: fsm, hazard unit and forwarding unit on loose ports
`timescale 1ns/1ps

module riscv_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_enable_i,
  input  logic                 illegal_insn_i,
  input  logic                 eret_insn_i,
  input  logic                 pipe_flush_i,
  input  logic                 instr_valid_i,
  input  logic                 data_req_ex_i,
  input  logic                 branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_t jump_in_dec_i,
  input  logic                 exc_req_i,
  input  logic                 ext_req_i,
  input  logic                 regfile_we_ex_i,
  input  logic                 regfile_we_wb_i,
  input  logic                 regfile_alu_we_fw_i,
  input  logic                 reg_d_wb_is_reg_a_i,
  input  logic                 reg_d_wb_is_reg_b_i,
  input  logic                 reg_d_alu_is_reg_a_i,
  input  logic                 reg_d_alu_is_reg_b_i,
  input  logic                 id_ready_i,
  input  logic                 ex_valid_i,
  output logic                 ctrl_busy_o,
  output logic                 is_decoding_o,
  output logic                 instr_req_o,
  output logic                 pc_set_o,
  output ctrl_pkg::pc_mux_t    pc_mux_o,
  output logic                 exc_ack_o,
  output logic                 exc_save_if_o,
  output logic                 exc_save_id_o,
  output logic                 exc_save_takenbranch_o,
  output logic                 exc_restore_id_o,
  output logic                 halt_if_o,
  output logic                 halt_id_o,
  output logic                 deassert_we_o,
  output logic                 load_stall_o,
  output logic                 jr_stall_o,
  output ctrl_pkg::fw_sel_t    operand_a_fw_mux_sel_o,
  output ctrl_pkg::fw_sel_t    operand_b_fw_mux_sel_o
);

  //////////////////////////////////////////////////////////////////////
  // control fsm
  //////////////////////////////////////////////////////////////////////

  // jr stall comes back from the hazard unit to hold the jalr redirect
  ctrl_fsm u_fsm (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_enable_i         (fetch_enable_i),
    .instr_valid_i          (instr_valid_i),
    .eret_insn_i            (eret_insn_i),
    .pipe_flush_i           (pipe_flush_i),
    .branch_taken_ex_i      (branch_taken_ex_i),
    .jump_in_dec_i          (jump_in_dec_i),
    .exc_req_i              (exc_req_i),
    .ext_req_i              (ext_req_i),
    .id_ready_i             (id_ready_i),
    .ex_valid_i             (ex_valid_i),
    .jr_stall_i             (jr_stall_o),
    .ctrl_busy_o            (ctrl_busy_o),
    .is_decoding_o          (is_decoding_o),
    .instr_req_o            (instr_req_o),
    .pc_set_o               (pc_set_o),
    .pc_mux_o               (pc_mux_o),
    .exc_ack_o              (exc_ack_o),
    .exc_save_if_o          (exc_save_if_o),
    .exc_save_id_o          (exc_save_id_o),
    .exc_save_takenbranch_o (exc_save_takenbranch_o),
    .exc_restore_id_o       (exc_restore_id_o),
    .halt_if_o              (halt_if_o),
    .halt_id_o              (halt_id_o)
  );

  //////////////////////////////////////////////////////////////////////
  // hazards on the decode side
  //////////////////////////////////////////////////////////////////////
  hazard_unit u_hazard (
    .is_decoding_i        (is_decoding_o),
    .illegal_insn_i       (illegal_insn_i),
    .data_req_ex_i        (data_req_ex_i),
    .regfile_we_ex_i      (regfile_we_ex_i),
    .regfile_we_wb_i      (regfile_we_wb_i),
    .regfile_alu_we_fw_i  (regfile_alu_we_fw_i),
    .reg_d_wb_is_reg_a_i  (reg_d_wb_is_reg_a_i),
    .reg_d_alu_is_reg_a_i (reg_d_alu_is_reg_a_i),
    .reg_d_alu_is_reg_b_i (reg_d_alu_is_reg_b_i),
    .jump_in_dec_i        (jump_in_dec_i),
    .load_stall_o         (load_stall_o),
    .jr_stall_o           (jr_stall_o),
    .deassert_we_o        (deassert_we_o)
  );

  // operand sources for EX, purely from the match flags
  fwd_unit u_fwd (
    .regfile_we_wb_i        (regfile_we_wb_i),
    .regfile_alu_we_fw_i    (regfile_alu_we_fw_i),
    .reg_d_wb_is_reg_a_i    (reg_d_wb_is_reg_a_i),
    .reg_d_wb_is_reg_b_i    (reg_d_wb_is_reg_b_i),
    .reg_d_alu_is_reg_a_i   (reg_d_alu_is_reg_a_i),
    .reg_d_alu_is_reg_b_i   (reg_d_alu_is_reg_b_i),
    .operand_a_fw_mux_sel_o (operand_a_fw_mux_sel_o),
    .operand_b_fw_mux_sel_o (operand_b_fw_mux_sel_o)
  );

endmodule

// File: bench/tb_clkgen.sv
// testbench clock and reset source: 40 ns clock, reset held for three cycles
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  // 20 ns high, 20 ns low
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // release just after the third rising edge, away from the sampling point
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #2 rst_n_o = 1'b1;
  end

endmodule

// File: bench/riscv_ctrl_props.sv
// concurrent checks on controller outputs: exception ack, idle fetch, boot pc pulse
`timescale 1ns/1ps

module riscv_ctrl_props (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              ctrl_busy_i,
  input logic              instr_req_i,
  input logic              pc_set_i,
  input ctrl_pkg::pc_mux_t pc_mux_i,
  input logic              exc_ack_i
);
  import ctrl_pkg::*;

  // an acknowledged exception always redirects fetch to the handler
  exc_ack_redirect: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exc_ack_i |-> (pc_set_i && (pc_mux_i == PC_EXCEPTION)))
    else $error("exc_ack_o without a pc_set to the exception vector");

  // idle controller neither fetches nor moves the pc
  idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !ctrl_busy_i |-> (!instr_req_i && !pc_set_i))
    else $error("fetch request or pc_set while the controller is idle");

  // boot address load is a single cycle pulse
  boot_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (pc_set_i && (pc_mux_i == PC_BOOT)) |=> !(pc_set_i && (pc_mux_i == PC_BOOT)))
    else $error("boot pc_set held for more than one cycle");

endmodule

bind riscv_ctrl riscv_ctrl_props u_props (
  .clk_i       (clk),
  .rst_n_i     (rst_n),
  .ctrl_busy_i (ctrl_busy_o),
  .instr_req_i (instr_req_o),
  .pc_set_i    (pc_set_o),
  .pc_mux_i    (pc_mux_o),
  .exc_ack_i   (exc_ack_o)
);

// File: bench/tb_riscv_ctrl.sv
// controller testbench with directed tests, lfsr stimulus, value checks and a watchdog
`timescale 1ns/1ps

module tb_riscv_ctrl;
  import ctrl_pkg::*;

  logic clk;
  logic rst_n;
  // dut inputs
  logic fetch_enable_i;
  logic illegal_insn_i;
  logic eret_insn_i;
  logic pipe_flush_i;
  logic instr_valid_i;
  logic data_req_ex_i;
  logic branch_taken_ex_i;
  logic exc_req_i;
  logic ext_req_i;
  logic regfile_we_ex_i;
  logic regfile_we_wb_i;
  logic regfile_alu_we_fw_i;
  logic reg_d_wb_is_reg_a_i;
  logic reg_d_wb_is_reg_b_i;
  logic reg_d_alu_is_reg_a_i;
  logic reg_d_alu_is_reg_b_i;
  logic id_ready_i;
  logic ex_valid_i;
  jump_kind_t jump_in_dec_i;
  // dut outputs
  logic ctrl_busy_o;
  logic is_decoding_o;
  logic instr_req_o;
  logic pc_set_o;
  logic exc_ack_o;
  logic exc_save_if_o;
  logic exc_save_id_o;
  logic exc_save_takenbranch_o;
  logic exc_restore_id_o;
  logic halt_if_o;
  logic halt_id_o;
  logic deassert_we_o;
  logic load_stall_o;
  logic jr_stall_o;
  pc_mux_t pc_mux_o;
  fw_sel_t operand_a_fw_mux_sel_o;
  fw_sel_t operand_b_fw_mux_sel_o;

  logic [31:0] lfsr_q;
  int unsigned err_cnt;
  int unsigned chk_cnt;

  tb_clkgen u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  riscv_ctrl u_riscv_ctrl (.*);

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  function automatic logic rand_bit();
    lfsr_q = lfsr_next(lfsr_q);
    return lfsr_q[0];
  endfunction

  // inputs change shortly after the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // outputs are combinational so sample well before the next edge
  task automatic settle();
    #5;
  endtask

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    chk_cnt++;
    assert (act_v === exp_v) else begin
      err_cnt++;
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
    end
  endtask

  // hazard, forwarding and exception inputs back to idle
  task automatic quiet_inputs();
    illegal_insn_i       = 1'b0;
    eret_insn_i          = 1'b0;
    pipe_flush_i         = 1'b0;
    data_req_ex_i        = 1'b0;
    branch_taken_ex_i    = 1'b0;
    exc_req_i            = 1'b0;
    ext_req_i            = 1'b0;
    regfile_we_ex_i      = 1'b0;
    regfile_we_wb_i      = 1'b0;
    regfile_alu_we_fw_i  = 1'b0;
    reg_d_wb_is_reg_a_i  = 1'b0;
    reg_d_wb_is_reg_b_i  = 1'b0;
    reg_d_alu_is_reg_a_i = 1'b0;
    reg_d_alu_is_reg_b_i = 1'b0;
    ex_valid_i           = 1'b0;
    jump_in_dec_i        = BRANCH_NONE;
  endtask

  // bounded wait for the first decode
  task automatic wait_decode(input int max_cycles);
    int n;
    n = 0;
    while (!is_decoding_o && (n < max_cycles)) begin
      next_cycle();
      settle();
      n++;
    end
    chk_cnt++;
    assert (is_decoding_o) else begin
      err_cnt++;
      $display("decode did not start within %0d cycles after the first fetch", max_cycles);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic boot_and_first_fetch();
    // still in RESET
    settle();
    check_val("ctrl_busy_o", 0, ctrl_busy_o);
    check_val("instr_req_o", 0, instr_req_o);
    check_val("pc_set_o", 0, pc_set_o);
    check_val("deassert_we_o", 1, deassert_we_o);
    next_cycle();
    fetch_enable_i = 1'b1;
    settle();
    check_val("pc_set_o", 0, pc_set_o);
    // BOOT_SET gives a single pc load
    next_cycle();
    id_ready_i = 1'b0;
    settle();
    check_val("pc_set_o", 1, pc_set_o);
    check_val("pc_mux_o", PC_BOOT, pc_mux_o);
    // FIRST_FETCH held by id_ready low
    next_cycle();
    settle();
    check_val("pc_set_o", 0, pc_set_o);
    check_val("ctrl_busy_o", 1, ctrl_busy_o);
    next_cycle();
    id_ready_i    = 1'b1;
    instr_valid_i = 1'b1;
    settle();
    check_val("is_decoding_o", 0, is_decoding_o);
    wait_decode(8);
  endtask

  task automatic forwarding_random();
    fw_sel_t exp_a;
    fw_sel_t exp_b;
    for (int i = 0; i < 40; i++) begin
      next_cycle();
      regfile_we_wb_i      = rand_bit();
      regfile_alu_we_fw_i  = rand_bit();
      reg_d_wb_is_reg_a_i  = rand_bit();
      reg_d_wb_is_reg_b_i  = rand_bit();
      reg_d_alu_is_reg_a_i = rand_bit();
      reg_d_alu_is_reg_b_i = rand_bit();
      settle();
      // EX result is newer than WB and the regfile comes last
      exp_a = (regfile_alu_we_fw_i && reg_d_alu_is_reg_a_i) ? SEL_FW_EX :
              (regfile_we_wb_i && reg_d_wb_is_reg_a_i) ? SEL_FW_WB : SEL_REGFILE;
      exp_b = (regfile_alu_we_fw_i && reg_d_alu_is_reg_b_i) ? SEL_FW_EX :
              (regfile_we_wb_i && reg_d_wb_is_reg_b_i) ? SEL_FW_WB : SEL_REGFILE;
      check_val("operand_a_fw_mux_sel_o", exp_a, operand_a_fw_mux_sel_o);
      check_val("operand_b_fw_mux_sel_o", exp_b, operand_b_fw_mux_sel_o);
    end
    next_cycle();
    quiet_inputs();
  endtask

  task automatic hazard_random();
    logic exp_load;
    logic exp_jr;
    for (int i = 0; i < 40; i++) begin
      next_cycle();
      data_req_ex_i        = rand_bit();
      regfile_we_ex_i      = rand_bit();
      regfile_we_wb_i      = rand_bit();
      regfile_alu_we_fw_i  = rand_bit();
      reg_d_wb_is_reg_a_i  = rand_bit();
      reg_d_alu_is_reg_a_i = rand_bit();
      reg_d_alu_is_reg_b_i = rand_bit();
      illegal_insn_i       = rand_bit();
      jump_in_dec_i        = rand_bit() ? BRANCH_JALR : BRANCH_NONE;
      settle();
      // load in EX feeding A or B
      exp_load = data_req_ex_i && regfile_we_ex_i &&
                 (reg_d_alu_is_reg_a_i || reg_d_alu_is_reg_b_i);
      // jalr base register still in flight
      exp_jr = (jump_in_dec_i == BRANCH_JALR) &&
               ((regfile_we_wb_i && reg_d_wb_is_reg_a_i) ||
                (regfile_we_ex_i && reg_d_alu_is_reg_a_i) ||
                (regfile_alu_we_fw_i && reg_d_alu_is_reg_a_i));
      check_val("is_decoding_o", 1, is_decoding_o);
      check_val("load_stall_o", exp_load, load_stall_o);
      check_val("jr_stall_o", exp_jr, jr_stall_o);
      check_val("deassert_we_o", illegal_insn_i || exp_load || exp_jr, deassert_we_o);
    end
    next_cycle();
    quiet_inputs();
    illegal_insn_i = 1'b1;
    settle();
    check_val("deassert_we_o", 1, deassert_we_o);
    next_cycle();
    illegal_insn_i = 1'b0;
    settle();
    check_val("deassert_we_o", 0, deassert_we_o);
  endtask

  task automatic jumps_and_branches();
    // jal while ID is stalled redirects once
    next_cycle();
    jump_in_dec_i = BRANCH_JAL;
    id_ready_i    = 1'b0;
    settle();
    check_val("pc_set_o", 1, pc_set_o);
    check_val("pc_mux_o", PC_JUMP, pc_mux_o);
    repeat (3) begin
      next_cycle();
      settle();
      check_val("pc_set_o", 0, pc_set_o);
    end
    next_cycle();
    id_ready_i = 1'b1;
    settle();
    check_val("pc_set_o", 0, pc_set_o);
    // jalr waits for its base register
    next_cycle();
    jump_in_dec_i       = BRANCH_JALR;
    regfile_we_wb_i     = 1'b1;
    reg_d_wb_is_reg_a_i = 1'b1;
    settle();
    check_val("jr_stall_o", 1, jr_stall_o);
    check_val("pc_set_o", 0, pc_set_o);
    next_cycle();
    regfile_we_wb_i = 1'b0;
    settle();
    check_val("pc_set_o", 1, pc_set_o);
    check_val("pc_mux_o", PC_JUMP, pc_mux_o);
    // taken branch kills the decode
    next_cycle();
    quiet_inputs();
    branch_taken_ex_i = 1'b1;
    settle();
    check_val("pc_set_o", 1, pc_set_o);
    check_val("pc_mux_o", PC_BRANCH, pc_mux_o);
    check_val("is_decoding_o", 0, is_decoding_o);
    next_cycle();
    quiet_inputs();
  endtask

  task automatic exceptions();
    exc_req_i = 1'b1;
    settle();
    check_val("exc_ack_o", 1, exc_ack_o);
    check_val("pc_mux_o", PC_EXCEPTION, pc_mux_o);
    check_val("exc_save_id_o", 1, exc_save_id_o);
    // interrupt on a taken branch resumes at the target
    next_cycle();
    quiet_inputs();
    ext_req_i         = 1'b1;
    branch_taken_ex_i = 1'b1;
    settle();
    check_val("exc_save_takenbranch_o", 1, exc_save_takenbranch_o);
    check_val("halt_id_o", 1, halt_id_o);
    check_val("pc_mux_o", PC_EXCEPTION, pc_mux_o);
    next_cycle();
    quiet_inputs();
    eret_insn_i = 1'b1;
    settle();
    check_val("pc_set_o", 1, pc_set_o);
    check_val("pc_mux_o", PC_ERET, pc_mux_o);
    check_val("exc_restore_id_o", 1, exc_restore_id_o);
    next_cycle();
    quiet_inputs();
  endtask

  task automatic flush_and_sleep();
    fetch_enable_i = 1'b0;
    pipe_flush_i   = 1'b1;
    settle();
    check_val("halt_if_o", 1, halt_if_o);
    check_val("halt_id_o", 1, halt_id_o);
    next_cycle();
    pipe_flush_i = 1'b0;
    // FLUSH_EX until EX drains
    repeat (3) begin
      settle();
      check_val("halt_if_o", 1, halt_if_o);
      check_val("halt_id_o", 1, halt_id_o);
      next_cycle();
    end
    ex_valid_i = 1'b1;
    settle();
    check_val("halt_if_o", 1, halt_if_o);
    check_val("halt_id_o", 1, halt_id_o);
    // FLUSH_WB
    next_cycle();
    ex_valid_i = 1'b0;
    settle();
    check_val("halt_if_o", 1, halt_if_o);
    check_val("halt_id_o", 1, halt_id_o);
    check_val("ctrl_busy_o", 1, ctrl_busy_o);
    // SLEEP until an interrupt wakes it
    next_cycle();
    exc_req_i = 1'b1;
    settle();
    check_val("ctrl_busy_o", 0, ctrl_busy_o);
    check_val("instr_req_o", 0, instr_req_o);
    next_cycle();
    settle();
    check_val("exc_ack_o", 1, exc_ack_o);
    check_val("exc_save_if_o", 1, exc_save_if_o);
    check_val("pc_mux_o", PC_EXCEPTION, pc_mux_o);
    next_cycle();
    quiet_inputs();
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    lfsr_q         = 32'hcd79_6c4f;
    err_cnt        = 0;
    chk_cnt        = 0;
    fetch_enable_i = 1'b0;
    instr_valid_i  = 1'b0;
    id_ready_i     = 1'b0;
    quiet_inputs();
    wait (rst_n === 1'b1);
    boot_and_first_fetch();
    forwarding_random();
    hazard_random();
    jumps_and_branches();
    exceptions();
    flush_and_sleep();
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // cycle budget per test plus margin
  initial begin
    int limit;
    limit = 3 + 12 + 42 + 44 + 16 + 8 + 14;
    limit = limit + 60;
    repeat (limit) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", limit);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: files.f
common/ctrl_pkg.sv
src/hazard_unit.sv
src/fwd_unit.sv
ctrl_fsm/ctrl_fsm.sv
src/riscv_ctrl.sv
bench/tb_clkgen.sv
bench/riscv_ctrl_props.sv
bench/tb_riscv_ctrl.sv
